//--- src/nabp_geometry_pkg.sv
`default_nettype none

package nabp_geometry_pkg;

    // projection angles per sinogram
    localparam int no_of_angles = 8;

    // detector samples per angle
    localparam int projection_line_size = 16;

    // whole sinogram, stored angle major
    localparam int sinogram_size = no_of_angles * projection_line_size;

    // filtered line banks, one credit each
    localparam int line_banks = 2;

    // angle index
    typedef logic [2:0] angle_t;

    // detector index within one projection line
    typedef logic [3:0] s_t;

    // angle * line size + detector index
    typedef logic [6:0] sg_addr_t;

    // filter credit counter, holds 0..line_banks
    typedef logic [1:0] credit_t;

endpackage

`default_nettype wire

//--- src/nabp_sample_pkg.sv
`default_nettype none

package nabp_sample_pkg;

    // raw detector sample from the host
    typedef logic signed [11:0] raw_sample_t;

    // filtered sample
    // 2x minus two neighbours needs two extra bits
    typedef logic signed [13:0] filt_sample_t;

    // host load port into the sinogram RAM
    typedef struct packed {
        logic                        valid;
        nabp_geometry_pkg::sg_addr_t addr;
        raw_sample_t                 data;
    } sg_write_t;

    // addresser to filter
    // valid = has next angle
    typedef struct packed {
        logic                        valid;
        nabp_geometry_pkg::angle_t   angle;
        nabp_geometry_pkg::sg_addr_t base;
    } angle_req_t;

    // filter to line store, one filtered sample
    typedef struct packed {
        logic                  valid;
        nabp_geometry_pkg::s_t index;
        filt_sample_t          data;
    } line_write_t;

    // line store to PE
    // angle only meaningful while ready
    typedef struct packed {
        logic                      ready;
        nabp_geometry_pkg::angle_t angle;
    } line_status_t;

endpackage

`default_nettype wire

//--- src/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram
#(
    parameter type sample_type = logic [7:0],
    parameter int  depth       = 16
)
(
    input  wire                     clk,
    input  wire                     wr_en,
    input  wire [$clog2(depth)-1:0] wr_addr,
    input  wire sample_type         wr_data,
    input  wire                     rd_en,
    input  wire [$clog2(depth)-1:0] rd_addr,
    output sample_type              rd_data
);

    // storage array
    sample_type mem [depth];

    // single write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read, data one cycle after rd_en
    // read during write returns the old word
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/sinogram_addresser.sv
`timescale 1ns/1ps
`default_nettype none

module sinogram_addresser
(
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        hs_kick,
    input  wire                        angle_take,
    output nabp_sample_pkg::angle_req_t angle_req,
    output logic                       hs_done
);

    import nabp_geometry_pkg::*;

    typedef enum logic {
        idle_s,
        work_s
    } state_t;

    state_t   state;
    state_t   next_state;
    angle_t   angle;
    sg_addr_t base;
    logic     take;

    // filter consumes the offered angle
    assign take = angle_take && angle_req.valid;

    // done = take on the final angle
    // marks dispatch of the last line, not its consumption
    // lines still queued downstream simply stall on credits
    assign hs_done = take && (angle == angle_t'(no_of_angles - 1));

    // offer an angle for the whole work phase
    always_comb
    begin
        angle_req.valid = (state == work_s);
        angle_req.angle = angle;
        angle_req.base  = base;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            idle_s:
                // kick only counts while idle
                if (hs_kick)
                    next_state = work_s;
            work_s:
                if (hs_done)
                    next_state = idle_s;
            default:
                next_state = idle_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= idle_s;
        else
            state <= next_state;
    end

    // angle and base address iterate together
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            angle <= '0;
            base  <= '0;
        end
        else if ((state == idle_s) && hs_kick)
        begin
            // restart from angle 0 on every run
            angle <= '0;
            base  <= '0;
        end
        else if (take)
        begin
            angle <= angle + angle_t'(1);
            // next projection line
            base  <= base + sg_addr_t'(projection_line_size);
        end
    end

endmodule

`default_nettype wire

//--- src/projection_filter.sv
`timescale 1ns/1ps
`default_nettype none

module projection_filter
(
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire nabp_sample_pkg::angle_req_t angle_req,
    output logic                         angle_take,
    output logic                         rd_en,
    output nabp_geometry_pkg::sg_addr_t  rd_addr,
    input  wire nabp_sample_pkg::raw_sample_t rd_data,
    output nabp_sample_pkg::line_write_t line_wr,
    output logic                         line_done,
    output nabp_geometry_pkg::angle_t    line_angle,
    input  wire                          credit_return
);

    import nabp_geometry_pkg::*;
    import nabp_sample_pkg::*;

    typedef enum logic {
        idle_s,
        run_s
    } state_t;

    // final step of a line: 16 reads then 2 drain cycles
    localparam int last_step = projection_line_size + 1;

    state_t       state;
    credit_t      credits;
    logic [4:0]   step;
    angle_t       angle_q;
    sg_addr_t     base_q;
    raw_sample_t  x_prev;
    raw_sample_t  x_cur;
    raw_sample_t  x_next;
    filt_sample_t y;
    logic         take;

    // start a line only with a free bank
    assign take       = (state == idle_s) && angle_req.valid && (credits != '0);
    assign angle_take = take;

    // s = 0 is read in the take cycle, s = step afterwards
    assign rd_en   = take || ((state == run_s) && (step < 5'(projection_line_size)));
    assign rd_addr = take ? angle_req.base : base_q + sg_addr_t'(step);

    // right neighbour past s = 15 reads as zero
    assign x_next = ((state == run_s) && (step <= 5'(projection_line_size))) ? rd_data : '0;

    // ramp kernel  2x[s] - x[s-1] - x[s+1]
    always_comb
    begin
        y = (filt_sample_t'(x_cur) <<< 1) - filt_sample_t'(x_prev) - filt_sample_t'(x_next);
    end

    // index s goes out once x[s+1] is on rd_data
    always_comb
    begin
        line_wr.valid = (state == run_s) && (step >= 5'd2);
        line_wr.index = s_t'(step - 5'd2);
        line_wr.data  = y;
    end

    assign line_done  = (state == run_s) && (step == 5'(last_step));
    assign line_angle = angle_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state   <= idle_s;
            credits <= credit_t'(line_banks);
            step    <= '0;
        end
        else
        begin
            // one credit spent per line, one back per released bank
            case ({take, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
            case (state)
                idle_s:
                    if (take)
                    begin
                        state <= run_s;
                        step  <= 5'd1;
                    end
                run_s:
                    if (step == 5'(last_step))
                        state <= idle_s;
                    else
                        step <= step + 5'd1;
                default:
                    state <= idle_s;
            endcase
        end
    end

    // line context and sample window
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            angle_q <= angle_req.angle;
            base_q  <= angle_req.base;
            // left neighbour of s = 0 is zero
            x_prev  <= '0;
            x_cur   <= '0;
        end
        else if (state == run_s)
        begin
            x_prev <= x_cur;
            x_cur  <= x_next;
        end
    end

endmodule

`default_nettype wire

//--- src/filtered_line_swap.sv
`timescale 1ns/1ps
`default_nettype none

module filtered_line_swap
(
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire nabp_sample_pkg::line_write_t line_wr,
    input  wire                              line_done,
    input  wire nabp_geometry_pkg::angle_t   line_angle,
    output logic                             credit_return,
    input  wire nabp_geometry_pkg::s_t       pe_s,
    output nabp_sample_pkg::filt_sample_t    pe_sample,
    input  wire                              pe_release,
    output nabp_sample_pkg::line_status_t    line_status
);

    import nabp_geometry_pkg::*;
    import nabp_sample_pkg::*;

    // bank pointers
    logic                  wr_bank;
    logic                  rd_bank;
    // read bank as seen by the data now on the RAM outputs
    logic                  rd_bank_q;
    logic [line_banks-1:0] bank_full;
    angle_t                bank_angle [line_banks];
    filt_sample_t          bank_rd_data [line_banks];
    logic                  release_ok;

    // release while not ready is ignored
    assign release_ok = pe_release && bank_full[rd_bank];

    // one RAM per bank
    for (genvar b = 0; b < line_banks; b++)
    begin : g_bank
        sample_ram
        #(
            .sample_type (filt_sample_t),
            .depth       (projection_line_size)
        )
        u_bank
        (
            .clk     (clk),
            .wr_en   (line_wr.valid && (wr_bank == 1'(b))),
            .wr_addr (line_wr.index),
            .wr_data (line_wr.data),
            .rd_en   (rd_bank == 1'(b)),
            .rd_addr (pe_s),
            .rd_data (bank_rd_data[b])
        );
    end

    // sample from the bank that was addressed last cycle
    assign pe_sample = bank_rd_data[rd_bank_q];

    always_comb
    begin
        line_status.ready = bank_full[rd_bank];
        line_status.angle = bank_angle[rd_bank];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_bank       <= 1'b0;
            rd_bank       <= 1'b0;
            rd_bank_q     <= 1'b0;
            bank_full     <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            rd_bank_q     <= rd_bank;
            // each accepted release hands one credit back
            credit_return <= release_ok;
            // completed line fills the write bank
            if (line_done)
            begin
                bank_full[wr_bank] <= 1'b1;
                wr_bank            <= ~wr_bank;
            end
            // write and read bank never coincide here
            if (release_ok)
            begin
                bank_full[rd_bank] <= 1'b0;
                rd_bank            <= ~rd_bank;
            end
        end
    end

    // angle tag per bank
    always_ff @(posedge clk)
    begin
        if (line_done)
            bank_angle[wr_bank] <= line_angle;
    end

endmodule

`default_nettype wire

//--- src/nabp_sinogram_feed.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_sinogram_feed
(
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire nabp_sample_pkg::sg_write_t sg_write,
    input  wire                            hs_kick,
    output logic                           hs_done,
    input  wire nabp_geometry_pkg::s_t     pe_s,
    input  wire                            pe_release,
    output nabp_sample_pkg::filt_sample_t  pe_sample,
    output nabp_sample_pkg::line_status_t  line_status
);

    import nabp_geometry_pkg::*;
    import nabp_sample_pkg::*;

    // addresser to filter
    angle_req_t  angle_req;
    logic        angle_take;

    // filter to sinogram RAM
    logic        rd_en;
    sg_addr_t    rd_addr;
    raw_sample_t rd_data;

    // filter to line store and credit path back
    line_write_t line_wr;
    logic        line_done;
    angle_t      line_angle;
    logic        credit_return;

    // raw sinogram, loaded by the host
    sample_ram
    #(
        .sample_type (raw_sample_t),
        .depth       (sinogram_size)
    )
    u_sinogram_ram
    (
        .clk     (clk),
        .wr_en   (sg_write.valid),
        .wr_addr (sg_write.addr),
        .wr_data (sg_write.data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // decode
    sinogram_addresser u_addresser
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .hs_kick    (hs_kick),
        .angle_take (angle_take),
        .angle_req  (angle_req),
        .hs_done    (hs_done)
    );

    // execute
    projection_filter u_filter
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .angle_req     (angle_req),
        .angle_take    (angle_take),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .line_wr       (line_wr),
        .line_done     (line_done),
        .line_angle    (line_angle),
        .credit_return (credit_return)
    );

    // result
    filtered_line_swap u_line_swap
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .line_wr       (line_wr),
        .line_done     (line_done),
        .line_angle    (line_angle),
        .credit_return (credit_return),
        .pe_s          (pe_s),
        .pe_sample     (pe_sample),
        .pe_release    (pe_release),
        .line_status   (line_status)
    );

endmodule

`default_nettype wire

//--- verification/nabp_sinogram_feed_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_sinogram_feed_assertions
(
    input wire                                     clk,
    input wire                                     reset_n,
    input wire nabp_geometry_pkg::credit_t         credits,
    input wire                                     dispatch_last,
    input wire                                     wr_valid,
    input wire                                     wr_bank,
    input wire [nabp_geometry_pkg::line_banks-1:0] bank_full
);

    import nabp_geometry_pkg::*;

    // one credit per bank at most
    credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
        credits <= credit_t'(line_banks))
        else $error("filter credit count above the number of banks");

    // done is a take on the final angle, so never two cycles wide
    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        dispatch_last |=> !dispatch_last)
        else $error("done pulse lasted more than one cycle");

    // credits must keep the filter off a bank the PE still holds
    bank_free: assert property (@(posedge clk) disable iff (!reset_n)
        wr_valid |-> !bank_full[wr_bank])
        else $error("line write into a bank that is still full");

endmodule

// filter side: credits and the final-angle take
bind projection_filter nabp_sinogram_feed_assertions u_filter_assertions
(
    .clk           (clk),
    .reset_n       (reset_n),
    .credits       (credits),
    .dispatch_last (angle_take && (angle_req.angle ==
                    nabp_geometry_pkg::angle_t'(nabp_geometry_pkg::no_of_angles - 1))),
    .wr_valid      (1'b0),
    .wr_bank       (1'b0),
    .bank_full     ('0)
);

// line store side: writes against the bank full flags
bind filtered_line_swap nabp_sinogram_feed_assertions u_swap_assertions
(
    .clk           (clk),
    .reset_n       (reset_n),
    .credits       ('0),
    .dispatch_last (1'b0),
    .wr_valid      (line_wr.valid),
    .wr_bank       (wr_bank),
    .bank_full     (bank_full)
);

`default_nettype wire

//--- verification/nabp_sinogram_feed_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_sinogram_feed_tb;

    import nabp_geometry_pkg::*;
    import nabp_sample_pkg::*;

    // longest wait for a single event, in cycles
    localparam int wait_limit   = 400;
    // stretch watched for stray lines or done pulses
    localparam int quiet_cycles = 60;

    logic         clk;
    logic         reset_n;
    sg_write_t    sg_write;
    logic         hs_kick;
    logic         hs_done;
    s_t           pe_s;
    logic         pe_release;
    filt_sample_t pe_sample;
    line_status_t line_status;

    // own copy of the loaded sinogram
    raw_sample_t sino [sinogram_size];

    int checks;
    int errors;
    int tests;
    int done_count;

    nabp_sinogram_feed dut
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .sg_write    (sg_write),
        .hs_kick     (hs_kick),
        .hs_done     (hs_done),
        .pe_s        (pe_s),
        .pe_release  (pe_release),
        .pe_sample   (pe_sample),
        .line_status (line_status)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hs_done is combinational, settled by the falling edge
    always @(negedge clk)
    begin
        if (reset_n && hs_done)
            done_count++;
    end

    // ramp kernel 2x[s] - x[s-1] - x[s+1], zero outside the line
    function automatic filt_sample_t filter_ref(int a, int s);
        int mid;
        int left;
        int right;
        mid   = sino[a * projection_line_size + s];
        left  = (s > 0) ? int'(sino[a * projection_line_size + s - 1]) : 0;
        right = (s < projection_line_size - 1) ?
                int'(sino[a * projection_line_size + s + 1]) : 0;
        return filt_sample_t'(2 * mid - left - right);
    endfunction

    task automatic check_sample(string name, filt_sample_t got, filt_sample_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_angle(string name, angle_t got, angle_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_done(string name, bit got, bit exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // random samples, optionally salted with full scale values
    task automatic load_sinogram(bit extremes);
        raw_sample_t v;
        for (int i = 0; i < sinogram_size; i++)
        begin
            v = raw_sample_t'($urandom);
            if (extremes)
            begin
                case ($urandom % 4)
                    0:       v = raw_sample_t'(2047);
                    1:       v = raw_sample_t'(-2047);
                    default: v = v;
                endcase
            end
            sino[i] = v;
            @(negedge clk);
            sg_write.valid = 1'b1;
            sg_write.addr  = sg_addr_t'(i);
            sg_write.data  = v;
        end
        @(negedge clk);
        sg_write = '0;
    endtask

    task automatic wait_ready(string what, output bit ok);
        int n;
        n = 0;
        while (!line_status.ready && (n < wait_limit))
        begin
            @(negedge clk);
            n++;
        end
        ok = line_status.ready;
        if (!ok)
        begin
            errors++;
            $display("timeout after %0d cycles waiting for %s to become ready", n, what);
        end
    endtask

    // pe_s goes out one edge ahead of its sample
    task automatic read_line(int a);
        filt_sample_t got;
        pe_s = '0;
        for (int s = 0; s < projection_line_size; s++)
        begin
            @(negedge clk);
            got = pe_sample;
            if (s < projection_line_size - 1)
                pe_s = s_t'(s + 1);
            check_sample($sformatf("pe_sample angle %0d s %0d", a, s), got, filter_ref(a, s));
        end
    endtask

    task automatic release_bank(int hold);
        repeat (hold) @(negedge clk);
        pe_release = 1'b1;
        @(negedge clk);
        pe_release = 1'b0;
    endtask

    // nothing may turn up while idle
    task automatic watch_quiet();
        repeat (quiet_cycles)
        begin
            @(negedge clk);
            check_done("line_status.ready", line_status.ready, 1'b0);
            check_done("hs_done", hs_done, 1'b0);
        end
    endtask

    task automatic report_test(string name, int errors_at_start);
        tests++;
        if (errors == errors_at_start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_at_start);
    endtask

    // one full kick: load, dispatch and consume all angles in order
    task automatic run_feed(string name, bit extremes, bit random_hold);
        int errors_at_start;
        int hold;
        bit ok;
        errors_at_start = errors;
        load_sinogram(extremes);
        done_count = 0;
        @(negedge clk);
        hs_kick = 1'b1;
        @(negedge clk);
        hs_kick = 1'b0;
        for (int a = 0; a < no_of_angles; a++)
        begin
            wait_ready($sformatf("line %0d", a), ok);
            if (!ok)
                break;
            check_angle("line_status.angle", line_status.angle, angle_t'(a));
            read_line(a);
            // PE may sit on the bank a while
            hold = random_hold ? int'($urandom % 41) : 0;
            release_bank(hold);
        end
        // no ninth line, no second done
        watch_quiet();
        checks++;
        if (done_count != 1)
        begin
            errors++;
            $display("hs_done pulsed %0d times in one run instead of once", done_count);
        end
        report_test(name, errors_at_start);
    endtask

    initial
    begin
        void'($urandom(32'hbef0));
        checks     = 0;
        errors     = 0;
        tests      = 0;
        done_count = 0;
        reset_n    = 1'b0;
        sg_write   = '0;
        hs_kick    = 1'b0;
        pe_s       = '0;
        pe_release = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        watch_quiet();
        report_test("idle_after_reset", 0);

        run_feed("immediate_release", 1'b0, 1'b0);
        run_feed("random_hold", 1'b0, 1'b1);
        run_feed("second_kick_extremes", 1'b1, 1'b0);

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/nabp_geometry_pkg.sv
src/nabp_sample_pkg.sv
src/sample_ram.sv
src/sinogram_addresser.sv
src/projection_filter.sv
src/filtered_line_swap.sv
src/nabp_sinogram_feed.sv
verification/nabp_sinogram_feed_assertions.sv
verification/nabp_sinogram_feed_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= nabp_sinogram_feed_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, status comes from the pass search
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
